/* include/cpuSettings_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// word size of the data path and the address bus.
`define DATA_WIDTH 16

// number of general purpose registers.
`define REG_COUNT 4

// pc value loaded while rstN is low.
`define RESET_VECTOR 16'h0000

`endif

/* sources.f */
+incdir+include
verilog/cpuPkg.sv
verilog/phaseSequencer.sv
verilog/instructionDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/programCounter.sv
verilog/busController.sv
verilog/core.sv
testbench/coreChecker.sv
testbench/coreTb.sv

/* testbench/coreChecker.sv */
`default_nettype none

`include "cpuSettings_settings.svh"

module coreChecker (
	input wire CLK,
	input wire rstN,
	input wire cpuPkg::word_t addr,
	input wire cpuPkg::word_t dout,
	input wire cpuPkg::word_t din,
	input wire rdN,
	input wire wrN,
	input wire fetch,
	input wire decode,
	input wire execute,
	input wire commit,
	input wire halted,
	output int errorCount
);
	import cpuPkg::*;

	logic [63:0] modelRegs; // r3..r0 with 16 bits each.
	logic [3:0] modelFlags; // {parity, sign, carry, zero}.
	word_t modelPc;
	word_t curInstr;
	logic modelHalt;
	logic haltDone;
	logic firstCycle;
	logic resetEdgeSeen;
	logic [3:0] expPhase; // one-hot {fetch, decode, execute, commit}.
	logic [63:0] nextRegs;
	logic [3:0] nextFlags;
	word_t nextPc;
	logic [1:0] accKind; // 0 none, 1 load, 2 store.
	word_t accAddr;
	word_t accData;
	logic [1:0] expStrobes;

	initial begin
		errorCount = 0;
		resetEdgeSeen = 1'b0;
	end

	task automatic reportMismatch(input string testName, input logic [15:0] expected,
			input logic [15:0] actual);
		errorCount++;
		$display("mismatch in %s: expected %h, actual %h", testName, expected, actual);
	endtask

	// instruction set model that steps one whole instruction per call.
	function automatic void stepModel(input word_t ins, input logic [63:0] regsIn,
			input logic [3:0] flagsIn, input word_t pcIn, input word_t loadWord,
			output logic [63:0] regsOut, output logic [3:0] flagsOut, output word_t pcOut,
			output logic [1:0] kind, output word_t busAddr, output word_t busData,
			output logic halt);
		logic [1:0] ia;
		logic [1:0] ib;
		word_t a;
		word_t b;
		word_t r;
		logic c;
		logic met;
		int ones;
		ia = ins[7:6];
		ib = ins[5:4];
		a = regsIn[ia*16 +: 16];
		b = regsIn[ib*16 +: 16];
		regsOut = regsIn;
		flagsOut = flagsIn;
		pcOut = pcIn + 16'd2;
		kind = 2'd0;
		busAddr = '0;
		busData = '0;
		halt = 1'b0;
		case (ins[15:14])
			2'b00: halt = (ins[10:8] == 3'b001);
			2'b01: begin
				if (ins[13])
					b = {12'h000, ins[3:0]};
				c = 1'b0;
				case (ins[12:10])
					3'd0: r = b;
					3'd1: begin
						r = a + b;
						c = (r < a); // wrapped around.
					end
					3'd3: r = a & b;
					3'd4: r = a | b;
					3'd5: r = a ^ b;
					3'd6: begin
						r = b << 1;
						c = b[15];
					end
					default: begin
						r = a - b; // sub and cmp.
						c = (a < b);
					end
				endcase
				ones = 0;
				for (int i = 0; i < 16; i++)
					ones += r[i];
				if (ins[12:10] != 3'd0)
					flagsOut = {(ones % 2) == 0, r[15], c, r == 16'h0000};
				if (ins[12:10] != 3'd7)
					regsOut[ia*16 +: 16] = r;
			end
			2'b10: begin
				busAddr = b;
				if (ins[12]) begin
					kind = 2'd2;
					busData = a;
				end else begin
					kind = 2'd1;
					regsOut[ia*16 +: 16] = loadWord;
				end
			end
			default: begin
				case (ins[13:12])
					2'b01: met = flagsIn[0];
					2'b10: met = flagsIn[1];
					2'b11: met = flagsIn[2];
					default: met = 1'b1;
				endcase
				if (met ^ ins[11])
					pcOut = pcIn + 16'd2 + {{7{ins[7]}}, ins[7:0], 1'b0};
			end
		endcase
	endfunction

	always @(posedge CLK) begin
		if (!rstN) begin
			// outputs are unknown until the first reset edge.
			if (resetEdgeSeen && ({rdN, wrN, halted, fetch, decode, execute, commit}
					!== 7'b1100000))
				reportMismatch("reset strobes", 7'b1100000,
					{rdN, wrN, halted, fetch, decode, execute, commit});
			resetEdgeSeen = 1'b1;
			modelRegs = '0;
			modelFlags = '0;
			modelPc = `RESET_VECTOR;
			modelHalt = 1'b0;
			haltDone = 1'b0;
			firstCycle = 1'b1;
			expPhase = 4'b1000;
		end else begin
			if (halted !== haltDone)
				reportMismatch("halted", haltDone, halted);
			if (!firstCycle && !haltDone) begin
				if ({fetch, decode, execute, commit} !== expPhase)
					reportMismatch("phase strobes", expPhase,
						{fetch, decode, execute, commit});
				expPhase = {expPhase[0], expPhase[3:1]};
			end
			if (firstCycle || haltDone) begin
				if ({fetch, decode, execute, commit, rdN, wrN} !== 6'b000011)
					reportMismatch(firstCycle ? "first idle cycle" : "idle after halt",
						6'b000011, {fetch, decode, execute, commit, rdN, wrN});
				firstCycle = 1'b0;
			end else if (fetch) begin
				if ({rdN, wrN} !== 2'b01)
					reportMismatch("fetch strobes", 2'b01, {rdN, wrN});
				if (addr !== modelPc)
					reportMismatch("fetch address", modelPc, addr);
				curInstr = din;
			end else if (execute) begin
				stepModel(curInstr, modelRegs, modelFlags, modelPc, din,
					nextRegs, nextFlags, nextPc, accKind, accAddr, accData, modelHalt);
				expStrobes = (accKind == 2'd1) ? 2'b01 : (accKind == 2'd2) ? 2'b10 : 2'b11;
				if ({rdN, wrN} !== expStrobes)
					reportMismatch("execute strobes", expStrobes, {rdN, wrN});
				if (accKind != 2'd0 && addr !== accAddr)
					reportMismatch("data address", accAddr, addr);
				if (accKind == 2'd2 && dout !== accData)
					reportMismatch("store data", accData, dout);
				modelRegs = nextRegs;
				modelFlags = nextFlags;
				modelPc = nextPc;
			end else begin
				if ({rdN, wrN} !== 2'b11)
					reportMismatch("bus idle", 2'b11, {rdN, wrN});
				if (commit)
					haltDone = modelHalt; // halted is seen from the next cycle on.
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/coreTb.sv */
`default_nettype none

module coreTb;
	import cpuPkg::*;

	logic CLK;
	logic rstN;
	word_t din;
	word_t addr;
	word_t dout;
	logic rdN;
	logic wrN;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic halted;
	int errorCount;
	logic [15:0] mem [256]; // byte address a holds word a/2.
	int progLen;
	int cycles;

	always #50 CLK = ~CLK;

	assign din = !rdN ? mem[addr[8:1]] : 16'h0000; // combinational read.

	always @(posedge CLK) begin
		if (!wrN)
			mem[addr[8:1]] <= dout;
	end

	function automatic word_t aluInstr(input logic immForm, input logic [2:0] op,
			input logic [1:0] a, input logic [1:0] b, input logic [3:0] imm);
		return {2'b01, immForm, op, 2'b00, a, b, imm};
	endfunction

	function automatic word_t loadStoreInstr(input logic store, input logic [1:0] a,
			input logic [1:0] b);
		return {2'b10, 1'b0, store, 4'h0, a, b, 4'h0};
	endfunction

	function automatic word_t jumpInstr(input logic [1:0] cond, input logic neg,
			input logic [7:0] offset);
		return {2'b11, cond, neg, 3'b000, offset};
	endfunction

	task automatic emit(input word_t w);
		mem[progLen] = w;
		progLen++;
	endtask

	// r3 becomes the pointer 0x1c0, then r0..r3 go to four words there.
	task automatic storeRegisters();
		emit(aluInstr(1'b1, 3'd0, 2'd3, 2'd0, 4'd7));
		repeat (6)
			emit(aluInstr(1'b0, 3'd6, 2'd3, 2'd3, 4'd0));
		for (int i = 0; i < 4; i++) begin
			emit(loadStoreInstr(1'b1, 2'(i), 2'd3));
			if (i < 3)
				emit(aluInstr(1'b1, 3'd1, 2'd3, 2'd0, 4'd2));
		end
	endtask

	// each condition with and without negate and each jump over one mov.
	task automatic jumpChecks();
		for (int c = 1; c < 4; c++) begin
			for (int n = 0; n < 2; n++) begin
				emit(jumpInstr(2'(c), 1'(n), 8'd1));
				emit(aluInstr(1'b1, 3'd0, 2'd1, 2'd0, 4'(c * 2 + n)));
			end
		end
	endtask

	core dut_i (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wrN(wrN),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.halted(halted)
	);

	coreChecker coreMon (
		.CLK(CLK),
		.rstN(rstN),
		.addr(addr),
		.dout(dout),
		.din(din),
		.rdN(rdN),
		.wrN(wrN),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.halted(halted),
		.errorCount(errorCount)
	);

	initial begin
		CLK = 1'b0;
		rstN = 1'b0;
		progLen = 0;
		void'($urandom(32'hea37));
		for (int i = 0; i < 256; i++)
			mem[i] = 16'(i * 16'h9e37) ^ 16'hc3a5;
		for (int i = 0; i < 4; i++)
			emit(aluInstr(1'b1, 3'd0, 2'(i), 2'd0, 4'(3 * i + 5)));
		for (int op = 0; op < 8; op++) begin
			emit(aluInstr(1'b0, 3'(op), 2'(op % 3), 2'((op + 1) % 4), 4'd0));
			emit(aluInstr(1'b1, 3'(op), 2'((op + 1) % 3), 2'd0, 4'(op + 9)));
		end
		storeRegisters();
		emit(aluInstr(1'b1, 3'd2, 2'd3, 2'd0, 4'd4)); // r3 = 0x1c2 where r1 was stored.
		emit(loadStoreInstr(1'b0, 2'd2, 2'd3));
		emit(aluInstr(1'b1, 3'd1, 2'd3, 2'd0, 4'd8));
		emit(loadStoreInstr(1'b1, 2'd2, 2'd3));
		emit(loadStoreInstr(1'b0, 2'd0, 2'd3)); // reads back the word just stored.
		emit(aluInstr(1'b1, 3'd1, 2'd3, 2'd0, 4'd2));
		emit(loadStoreInstr(1'b0, 2'd1, 2'd3)); // untouched fill word.
		storeRegisters(); // makes the loaded words visible.
		emit(aluInstr(1'b0, 3'd7, 2'd0, 2'd0, 4'd0)); // zero set, carry and sign clear.
		jumpChecks();
		emit(aluInstr(1'b1, 3'd0, 2'd2, 2'd0, 4'd1));
		emit(aluInstr(1'b1, 3'd7, 2'd2, 2'd0, 4'd2)); // 1 - 2 sets carry and sign.
		jumpChecks();
		emit(jumpInstr(2'd0, 1'b0, 8'd1));
		emit(aluInstr(1'b1, 3'd0, 2'd1, 2'd0, 4'd15));
		repeat (40)
			emit(aluInstr(1'($urandom), 3'($urandom), 2'($urandom % 3), 2'($urandom),
				4'($urandom)));
		storeRegisters();
		emit(16'h0100); // halt.
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
		cycles = 0;
		while (!halted && cycles < 5000) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: the core did not halt within 5000 cycles");
			$display("errors: %0d", errorCount);
			$display("Test FAILED");
		end else begin
			repeat (20) @(negedge CLK); // core must stay idle.
			$display("errors: %0d", errorCount);
			if (errorCount == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

`include "cpuSettings_settings.svh"

module alu (
	input wire CLK,
	input wire rstN,
	input wire commit,
	input wire cpuPkg::word_t rdA,
	input wire cpuPkg::word_t rdB,
	input wire cpuPkg::aluOp_t aluOp,
	input wire useImm,
	input wire [3:0] imm,
	input wire flagWrite,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flags
);
	import cpuPkg::*;

	word_t opB;
	logic [`DATA_WIDTH:0] wide; // carry or borrow in the top bit.
	flags_t nextFlags;

	assign opB = useImm ? word_t'(imm) : rdB;

	always_comb begin
		case (aluOp)
			MOV: wide = {1'b0, opB};
			ADD: wide = {1'b0, rdA} + {1'b0, opB};
			SUB: wide = {1'b0, rdA} - {1'b0, opB};
			CMP: wide = {1'b0, rdA} - {1'b0, opB};
			AND: wide = {1'b0, rdA & opB};
			OR: wide = {1'b0, rdA | opB};
			XOR: wide = {1'b0, rdA ^ opB};
			SHL: wide = {opB, 1'b0}; // bit 15 falls into carry.
			default: wide = {1'b0, opB};
		endcase
	end

	assign result = wide[`DATA_WIDTH-1:0];

	always_comb begin
		nextFlags[FLAG_ZERO] = (result == '0);
		nextFlags[FLAG_CARRY] = wide[`DATA_WIDTH]; // logic ops leave this at zero.
		nextFlags[FLAG_SIGN] = result[`DATA_WIDTH-1];
		nextFlags[FLAG_PARITY] = ~^result; // even number of ones.
	end

	always_ff @(posedge CLK) begin
		if (!rstN)
			flags <= '0;
		else if (commit && flagWrite)
			flags <= nextFlags;
	end

endmodule

`default_nettype wire

/* verilog/busController.sv */
`default_nettype none

module busController (
	input wire CLK,
	input wire rstN,
	input wire fetch,
	input wire execute,
	input wire cpuPkg::word_t pc,
	input wire cpuPkg::word_t rdA,
	input wire cpuPkg::word_t rdB,
	input wire memRead,
	input wire memWrite,
	input wire cpuPkg::word_t din,
	output cpuPkg::word_t addr,
	output cpuPkg::word_t dout,
	output logic rdN,
	output logic wrN,
	output cpuPkg::word_t loadData
);
	logic loadCycle;
	logic storeCycle;

	assign loadCycle = execute && memRead;
	assign storeCycle = execute && memWrite;

	// register B points at memory for data accesses, pc otherwise.
	assign addr = (loadCycle || storeCycle) ? rdB : pc;

	assign dout = storeCycle ? rdA : '0; // quiet outside a store.

	assign rdN = !(fetch || loadCycle);
	assign wrN = !storeCycle;

	always_ff @(posedge CLK) begin
		if (!rstN)
			loadData <= '0;
		else if (loadCycle)
			loadData <= din; // written back at commit.
	end

endmodule

`default_nettype wire

/* verilog/core.sv */
`default_nettype none

module core (
	input wire CLK,
	input wire rstN,
	input wire cpuPkg::word_t din,
	output cpuPkg::word_t addr,
	output cpuPkg::word_t dout,
	output logic rdN,
	output logic wrN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic halted
);
	import cpuPkg::*;

	word_t instr;
	logic isHalt;
	regIdx_t regAIdx;
	regIdx_t regBIdx;
	aluOp_t aluOp;
	logic useImm;
	logic [3:0] imm;
	logic regWrite;
	logic flagWrite;
	logic memRead;
	logic memWrite;
	logic branchTaken;
	logic [7:0] branchOffset;
	word_t result;
	flags_t flags;
	word_t rdA;
	word_t rdB;
	word_t loadData;
	word_t pc;

	phaseSequencer phaseSequencerInst (
		.CLK(CLK),
		.rstN(rstN),
		.din(din),
		.isHalt(isHalt),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit),
		.instr(instr),
		.halted(halted)
	);

	instructionDecoder instructionDecoderInst (
		.instr(instr),
		.flags(flags),
		.regAIdx(regAIdx),
		.regBIdx(regBIdx),
		.aluOp(aluOp),
		.useImm(useImm),
		.imm(imm),
		.regWrite(regWrite),
		.flagWrite(flagWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.isHalt(isHalt)
	);

	alu aluInst (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.rdA(rdA),
		.rdB(rdB),
		.aluOp(aluOp),
		.useImm(useImm),
		.imm(imm),
		.flagWrite(flagWrite),
		.result(result),
		.flags(flags)
	);

	registerFile registerFileInst (
		.CLK(CLK),
		.rstN(rstN),
		.regAIdx(regAIdx),
		.regBIdx(regBIdx),
		.we(regWrite && commit),
		.wrData(memRead ? loadData : result), // load data or alu result.
		.rdA(rdA),
		.rdB(rdB)
	);

	programCounter programCounterInst (
		.CLK(CLK),
		.rstN(rstN),
		.commit(commit),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.pc(pc)
	);

	busController busControllerInst (
		.CLK(CLK),
		.rstN(rstN),
		.fetch(fetch),
		.execute(execute),
		.pc(pc),
		.rdA(rdA),
		.rdB(rdB),
		.memRead(memRead),
		.memWrite(memWrite),
		.din(din),
		.addr(addr),
		.dout(dout),
		.rdN(rdN),
		.wrN(wrN),
		.loadData(loadData)
	);

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

`include "cpuSettings_settings.svh"

package cpuPkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;          // data or address word.
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t; // register number.
	typedef logic [3:0] flags_t;                      // {parity, sign, carry, zero}.

	// bit positions inside flags_t
	localparam int FLAG_ZERO = 0;
	localparam int FLAG_CARRY = 1;
	localparam int FLAG_SIGN = 2;
	localparam int FLAG_PARITY = 3;

	typedef enum logic [2:0] {
		MOV, ADD, SUB, AND, OR, XOR, SHL, CMP
	} aluOp_t;

	typedef enum logic [1:0] {
		GENERAL, ALU, LDST, JUMP
	} group_t;

	typedef enum logic [1:0] {
		FETCH, DECODE, EXECUTE, COMMIT
	} phase_t;

	localparam logic [2:0] GEN_HALT = 3'b001; // the only general op that is not a nop.

	// values of the jump condition field in instr[13:12].
	localparam logic [1:0] COND_ALWAYS = 2'b00;
	localparam logic [1:0] COND_ZERO = 2'b01;
	localparam logic [1:0] COND_CARRY = 2'b10;
	localparam logic [1:0] COND_SIGN = 2'b11;

endpackage

`default_nettype wire

/* verilog/instructionDecoder.sv */
`default_nettype none

module instructionDecoder (
	input wire cpuPkg::word_t instr,
	input wire cpuPkg::flags_t flags,
	output cpuPkg::regIdx_t regAIdx,
	output cpuPkg::regIdx_t regBIdx,
	output cpuPkg::aluOp_t aluOp,
	output logic useImm,
	output logic [3:0] imm,
	output logic regWrite,
	output logic flagWrite,
	output logic memRead,
	output logic memWrite,
	output logic branchTaken,
	output logic [7:0] branchOffset,
	output logic isHalt
);
	import cpuPkg::*;

	group_t group;
	logic condMet;
	logic isStore;

	assign group = group_t'(instr[15:14]);
	assign isStore = instr[12]; // load/store direction.

	// fields sit at fixed positions in every group.
	assign regAIdx = instr[7:6];
	assign regBIdx = instr[5:4];
	assign aluOp = aluOp_t'(instr[12:10]);
	assign imm = instr[3:0];
	assign branchOffset = instr[7:0]; // signed word count.

	always_comb begin
		case (instr[13:12])
			COND_ZERO: condMet = flags[FLAG_ZERO];
			COND_CARRY: condMet = flags[FLAG_CARRY];
			COND_SIGN: condMet = flags[FLAG_SIGN];
			default: condMet = 1'b1; // always.
		endcase
	end

	always_comb begin
		useImm = 1'b0;
		regWrite = 1'b0;
		flagWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchTaken = 1'b0;
		isHalt = 1'b0;
		case (group)
			GENERAL: begin
				isHalt = (instr[10:8] == GEN_HALT);
			end
			ALU: begin
				useImm = instr[13];
				regWrite = (aluOp != CMP); // compare only sets flags.
				flagWrite = (aluOp != MOV);
			end
			LDST: begin
				memRead = !isStore;
				memWrite = isStore;
				regWrite = !isStore; // loaded word goes to register A.
			end
			JUMP: begin
				branchTaken = condMet ^ instr[11]; // negate bit inverts the test.
			end
			default: begin
				isHalt = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/phaseSequencer.sv */
`default_nettype none

module phaseSequencer (
	input wire CLK,
	input wire rstN,
	input wire cpuPkg::word_t din,
	input wire isHalt,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output cpuPkg::word_t instr,
	output logic halted
);
	import cpuPkg::*;

	phase_t phase;
	logic started; // set by the first edge after reset.
	logic running;

	assign running = started && !halted;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= FETCH;
			started <= 1'b0;
			halted <= 1'b0;
		end else begin
			started <= 1'b1;
			if (commit && isHalt)
				halted <= 1'b1; // stays set until reset.
			if (running) begin
				case (phase)
					FETCH: phase <= DECODE;
					DECODE: phase <= EXECUTE;
					EXECUTE: phase <= COMMIT;
					default: phase <= FETCH;
				endcase
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch)
			instr <= din; // word read at pc.
	end

	assign fetch = running && (phase == FETCH);
	assign decode = running && (phase == DECODE);
	assign execute = running && (phase == EXECUTE);
	assign commit = running && (phase == COMMIT);

endmodule

`default_nettype wire

/* verilog/programCounter.sv */
`default_nettype none

`include "cpuSettings_settings.svh"

module programCounter (
	input wire CLK,
	input wire rstN,
	input wire commit,
	input wire branchTaken,
	input wire [7:0] branchOffset,
	output cpuPkg::word_t pc
);
	import cpuPkg::*;

	word_t seqPc;
	word_t byteOffset;
	word_t target;

	assign seqPc = pc + word_t'(2); // next word.

	// sign extend and turn the word count into bytes.
	assign byteOffset = {{(`DATA_WIDTH-9){branchOffset[7]}}, branchOffset, 1'b0};

	assign target = seqPc + byteOffset; // relative to the following instruction.

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= `RESET_VECTOR;
		end else if (commit) begin
			if (branchTaken)
				pc <= target;
			else
				pc <= seqPc;
		end
	end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

`include "cpuSettings_settings.svh"

module registerFile (
	input wire CLK,
	input wire rstN,
	input wire cpuPkg::regIdx_t regAIdx,
	input wire cpuPkg::regIdx_t regBIdx,
	input wire we,
	input wire cpuPkg::word_t wrData,
	output cpuPkg::word_t rdA,
	output cpuPkg::word_t rdB
);
	import cpuPkg::*;

	word_t regs [`REG_COUNT];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[regAIdx] <= wrData; // only register A is ever written.
		end
	end

	// both read ports are asynchronous.
	assign rdA = regs[regAIdx];
	assign rdB = regs[regBIdx];

endmodule

`default_nettype wire
